//--- Makefile
# Verilator build and regression run for the branch prediction unit

VERILATOR ?= verilator
TOP       ?= branch_pred_tb
FILELIST  ?= branch_pred_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash or the fail message in the log both fail the run
run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- branch_pred_top.f
source/bp_pkg.sv
source/bp_btb.sv
source/bp_gshare.sv
source/bp_csr_apb.sv
source/branch_pred_top.sv
dv/branch_pred_properties.sv
dv/branch_pred_tb.sv

//--- dv/branch_pred_properties.sv
// Bound assertions on reset, APB ready, flush and fall-through rules of the branch predictor
`timescale 1ns/1ps
`default_nettype none

module branch_pred_properties (
    input wire                     clk,
    input wire                     reset_i,
    input wire bp_pkg::addr_t      fetch_pc_i,
    input wire                     pred_taken_i,
    input wire bp_pkg::addr_t      pred_target_i,
    input wire                     pready_i,
    input wire                     flush_i,
    input wire                     btb_hit_i
);

    // BTB is empty once reset has been applied
    reset_not_taken: assert property (@(posedge clk) reset_i |=> !pred_taken_i)
        else $error("pred_taken_o high in the cycle after reset");

    // Single phase APB slave
    ready_high: assert property (@(posedge clk) pready_i)
        else $error("pready_o dropped low");

    // Flush pulse empties the BTB on its edge
    flush_miss: assert property (@(posedge clk) disable iff (reset_i) flush_i |=> !btb_hit_i)
        else $error("BTB hit in the cycle after a flush");

    // Miss always falls through to the next word
    miss_target: assert property (@(posedge clk) disable iff (reset_i)
        !btb_hit_i |-> (pred_target_i == fetch_pc_i + 32'd4))
        else $error("pred_target_o is not fetch_pc_i+4 on a BTB miss");

endmodule

bind branch_pred_top branch_pred_properties props_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_pc_i    (fetch_pc_i),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .pready_i      (pready_o),
    .flush_i       (flush),
    .btb_hit_i     (btb_hit)
);

`default_nettype wire

//--- dv/branch_pred_tb.sv
// Testbench for the branch prediction unit with random fetch and update traffic and a reference model
`timescale 1ns/1ps
`default_nettype none

module branch_pred_tb;

    localparam int APB_TIMEOUT = 16;
    // R-type ALU opcode, never trains the predictor
    localparam bp_pkg::opcode_t OP_ALU = 7'b0110011;

    logic                    clk;
    logic                    reset_i;
    logic                    fetch_valid_i;
    bp_pkg::addr_t           fetch_pc_i;
    logic                    pred_taken_o;
    bp_pkg::addr_t           pred_target_o;
    bp_pkg::pht_idx_t        pred_pht_index_o;
    logic                    update_valid_i;
    bp_pkg::addr_t           update_pc_i;
    bp_pkg::opcode_t         update_op_i;
    logic                    update_taken_i;
    bp_pkg::addr_t           update_target_i;
    bp_pkg::pht_idx_t        update_pht_index_i;
    logic                    psel_i;
    logic                    penable_i;
    logic                    pwrite_i;
    bp_pkg::apb_addr_t       paddr_i;
    logic [31:0]             pwdata_i;
    logic [31:0]             prdata_o;
    logic                    pready_o;
    logic                    pslverr_o;

    // Reference model state
    logic                    m_valid  [32];
    logic [24:0]             m_tag    [32];
    bp_pkg::addr_t           m_target [32];
    logic                    m_jump   [32];
    logic [1:0]              m_pht    [32];
    logic [4:0]              m_ghr;
    logic                    m_enable;
    logic [31:0]             m_lookups;
    logic [31:0]             m_hits;

    // Pairs 0/3, 1/4 and 5/6 share a BTB index with different tags
    bp_pkg::addr_t           pc_pool [8];
    bp_pkg::opcode_t         op_pool [4];

    string                   test_name;
    int                      errors;
    int                      errors_at_start;
    int                      tests;

    branch_pred_top branch_pred_top_i (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected=%h actual=%h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    // One fetch and one update in the same cycle, checked at the falling edge
    task automatic run_cycle(input logic fv, input bp_pkg::addr_t pc, input logic uv,
                             input bp_pkg::addr_t upc, input bp_pkg::opcode_t op,
                             input logic tk, input bp_pkg::addr_t tgt);
        logic [4:0]     idx;
        logic [4:0]     pidx;
        logic [4:0]     uidx;
        logic [4:0]     upd_idx;
        logic           hit;
        logic           exp_taken;
        bp_pkg::addr_t  exp_target;
        // Execute stage hands back the index that fetch saw
        upd_idx = upc[6:2] ^ m_ghr;
        @(posedge clk);
        fetch_valid_i      <= fv;
        fetch_pc_i         <= pc;
        update_valid_i     <= uv;
        update_pc_i        <= upc;
        update_op_i        <= op;
        update_taken_i     <= tk;
        update_target_i    <= tgt;
        update_pht_index_i <= upd_idx;
        @(negedge clk);
        idx = pc[6:2];
        pidx = pc[6:2] ^ m_ghr;
        hit = m_valid[idx] && (m_tag[idx] == pc[31:7]);
        exp_taken = 1'b0;
        exp_target = pc + 32'd4;
        if (m_enable && hit) begin
            exp_target = m_target[idx];
            exp_taken = m_jump[idx] ? 1'b1 : m_pht[pidx][1];
        end
        check_value("pred_taken", 32'(exp_taken), 32'(pred_taken_o));
        check_value("pred_target", exp_target, pred_target_o);
        check_value("pht_index", 32'(pidx), 32'(pred_pht_index_o));
        // Counts see the raw hit, enable does not matter
        if (fv) begin
            m_lookups++;
            if (hit) begin
                m_hits++;
            end
        end
        if (uv && (op == bp_pkg::OP_BRANCH || op == bp_pkg::OP_JAL || op == bp_pkg::OP_JALR)) begin
            uidx = upc[6:2];
            m_valid[uidx] = 1'b1;
            m_tag[uidx] = upc[31:7];
            m_target[uidx] = tgt;
            m_jump[uidx] = (op != bp_pkg::OP_BRANCH);
        end
        if (uv && op == bp_pkg::OP_BRANCH) begin
            if (tk && m_pht[upd_idx] != 2'b11) begin
                m_pht[upd_idx] = m_pht[upd_idx] + 2'd1;
            end else if (!tk && m_pht[upd_idx] != 2'b00) begin
                m_pht[upd_idx] = m_pht[upd_idx] - 2'd1;
            end
            m_ghr = {tk, m_ghr[4:1]};
        end
    endtask

    task automatic random_cycle(input logic branches_only);
        bp_pkg::opcode_t op;
        op = branches_only ? bp_pkg::OP_BRANCH : op_pool[$urandom_range(0, 3)];
        run_cycle($urandom_range(0, 3) != 0, pc_pool[$urandom_range(0, 7)],
                  $urandom_range(0, 1) == 1, pc_pool[$urandom_range(0, 7)], op,
                  $urandom_range(0, 1) == 1, $urandom() & 32'hffff_fffc);
    endtask

    // Setup phase, then access phase held until pready
    task automatic apb_access(input logic wr, input bp_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        fetch_valid_i  <= 1'b0;
        update_valid_i <= 1'b0;
        psel_i         <= 1'b1;
        penable_i      <= 1'b0;
        pwrite_i       <= wr;
        paddr_i        <= addr;
        pwdata_i       <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        while (!pready_o && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (pready_o) else begin
            $display("ERROR %s APB access to offset %h timed out waiting for pready",
                     test_name, addr);
            errors++;
        end
        rdata = prdata_o;
        err = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic reg_write(input bp_pkg::apb_addr_t addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value("pslverr", 32'd0, 32'(err));
        if (addr == bp_pkg::REG_CTRL) begin
            m_enable = data[0];
            // Flush lands one edge after the access, before the next fetch
            if (data[1]) begin
                m_ghr = '0;
                for (int i = 0; i < 32; i++) begin
                    m_valid[i] = 1'b0;
                end
            end
        end
    endtask

    task automatic read_check(input string what, input bp_pkg::apb_addr_t addr,
                              input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        check_value(what, exp, rdata);
        check_value("pslverr", 32'd0, 32'(err));
    endtask

    task automatic fetch_pool();
        for (int i = 0; i < 8; i++) begin
            run_cycle(1'b1, pc_pool[i], 1'b0, 32'd0, OP_ALU, 1'b0, 32'd0);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        void'($urandom(551));
        clk = 1'b0;
        reset_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i = '0;
        update_valid_i = 1'b0;
        update_pc_i = '0;
        update_op_i = '0;
        update_taken_i = 1'b0;
        update_target_i = '0;
        update_pht_index_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        errors = 0;
        tests = 0;
        pc_pool = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1008, 32'h0000_2000,
                    32'h0000_2004, 32'h0000_1010, 32'h0000_3010, 32'h0000_107c};
        op_pool = '{bp_pkg::OP_BRANCH, bp_pkg::OP_JAL, bp_pkg::OP_JALR, OP_ALU};
        for (int i = 0; i < 32; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_target[i] = '0;
            m_jump[i] = 1'b0;
            m_pht[i] = 2'b01;
        end
        m_ghr = '0;
        m_enable = 1'b1;
        m_lookups = '0;
        m_hits = '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        begin_test("reset");
        // Idle bus after reset
        @(negedge clk);
        check_value("idle_prdata", 32'd0, prdata_o);
        check_value("idle_pslverr", 32'd0, 32'(pslverr_o));
        read_check("ctrl", bp_pkg::REG_CTRL, 32'd1);
        read_check("ghr", bp_pkg::REG_GHR, 32'd0);
        read_check("lookups", bp_pkg::REG_LOOKUPS, 32'd0);
        read_check("hits", bp_pkg::REG_HITS, 32'd0);
        fetch_pool();
        end_test();

        // Jumps at two indices, then the aliases at the same indices
        begin_test("jump_hit");
        run_cycle(1'b0, pc_pool[0], 1'b1, pc_pool[0], bp_pkg::OP_JAL, 1'b1, 32'h0000_4000);
        run_cycle(1'b0, pc_pool[1], 1'b1, pc_pool[1], bp_pkg::OP_JALR, 1'b1, 32'h0000_5020);
        fetch_pool();
        end_test();

        begin_test("branch_train");
        repeat (300) random_cycle(1'b1);
        read_check("ghr", bp_pkg::REG_GHR, 32'(m_ghr));
        end_test();

        begin_test("alu_update");
        repeat (40) begin
            run_cycle(1'b1, pc_pool[$urandom_range(0, 7)], 1'b1, pc_pool[$urandom_range(0, 7)],
                      OP_ALU, $urandom_range(0, 1) == 1, $urandom() & 32'hffff_fffc);
        end
        read_check("ghr", bp_pkg::REG_GHR, 32'(m_ghr));
        end_test();

        // Tables keep training while prediction is off
        begin_test("disable");
        reg_write(bp_pkg::REG_CTRL, 32'd0);
        read_check("ctrl", bp_pkg::REG_CTRL, 32'd0);
        repeat (200) random_cycle(1'b0);
        reg_write(bp_pkg::REG_CTRL, 32'd1);
        fetch_pool();
        end_test();

        begin_test("flush");
        reg_write(bp_pkg::REG_CTRL, 32'd3);
        read_check("ctrl", bp_pkg::REG_CTRL, 32'd1);
        read_check("ghr", bp_pkg::REG_GHR, 32'd0);
        fetch_pool();
        // Counters survive, retrained entries use the old values
        repeat (60) random_cycle(1'b1);
        fetch_pool();
        read_check("lookups", bp_pkg::REG_LOOKUPS, m_lookups);
        read_check("hits", bp_pkg::REG_HITS, m_hits);
        apb_access(1'b0, 4'h2, 32'd0, rdata, err);
        check_value("unmapped_pslverr", 32'd1, 32'(err));
        end_test();

        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bp_btb.sv
// Branch target buffer, direct mapped, full tag compare with overwrite on every resolved jump
`timescale 1ns/1ps
`default_nettype none

module bp_btb (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     flush_i,
    // Fetch side lookup
    input  wire bp_pkg::addr_t      lookup_pc_i,
    // Write port from the execute stage
    input  wire                     wr_en_i,
    input  wire bp_pkg::addr_t      wr_pc_i,
    input  wire bp_pkg::addr_t      wr_target_i,
    input  wire bp_pkg::br_kind_t   wr_kind_i,
    // Lookup result
    output logic                    hit_o,
    output bp_pkg::br_kind_t        kind_o,
    output bp_pkg::addr_t           target_o
);

    // Entry storage
    logic              valid_q  [bp_pkg::BTB_ENTRIES];
    bp_pkg::btb_tag_t  tag_q    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t     target_q [bp_pkg::BTB_ENTRIES];
    bp_pkg::br_kind_t  kind_q   [bp_pkg::BTB_ENTRIES];

    // Split PCs into index and tag
    bp_pkg::btb_idx_t  lookup_idx;
    bp_pkg::btb_tag_t  lookup_tag;
    bp_pkg::btb_idx_t  wr_idx;
    bp_pkg::btb_tag_t  wr_tag;

    // Combinational hit for the current fetch PC
    logic              lookup_hit;

    assign lookup_idx = lookup_pc_i[6:2];
    assign lookup_tag = lookup_pc_i[31:7];
    assign wr_idx     = wr_pc_i[6:2];
    assign wr_tag     = wr_pc_i[31:7];

    // Valid bits
    // Flush and reset drop every entry at once
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag, target and kind
    // Overwritten unconditionally, no replacement check
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
            kind_q[wr_idx]   <= wr_kind_i;
        end
    end

    // Tag match only counts on a valid entry
    assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

    assign hit_o = lookup_hit;

    // Kind reads as none on a miss so stale entries never steer fetch
    assign kind_o = lookup_hit ? kind_q[lookup_idx] : bp_pkg::KIND_NONE;

    // Target passed through, top picks the fall-through on a miss
    assign target_o = target_q[lookup_idx];

endmodule

`default_nettype wire

//--- source/bp_csr_apb.sv
// APB3 register block for predictor enable, flush pulse, history readback and event counters
`timescale 1ns/1ps
`default_nettype none

module bp_csr_apb (
    input  wire                     clk,
    input  wire                     reset_i,
    // APB3 slave
    input  wire                     psel_i,
    input  wire                     penable_i,
    input  wire                     pwrite_i,
    input  wire bp_pkg::apb_addr_t  paddr_i,
    input  wire [31:0]              pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    // Events and status from the predictor
    input  wire                     lookup_i,
    input  wire                     hit_i,
    input  wire bp_pkg::ghr_t       ghr_i,
    // Control outputs
    output logic                    enable_o,
    output logic                    flush_o
);

    logic         enable_q;
    logic         flush_q;
    logic [31:0]  lookups_q;
    logic [31:0]  hits_q;

    logic         wr_access;
    logic         rd_access;
    logic         addr_mapped;
    logic [31:0]  rd_data;

    // Every transfer completes in its access phase
    assign wr_access = psel_i && penable_i && pwrite_i;
    assign rd_access = psel_i && penable_i && !pwrite_i;

    // Address decode and read mux
    always_comb begin
        addr_mapped = 1'b1;
        rd_data     = '0;
        case (paddr_i)
            bp_pkg::REG_CTRL:    rd_data = {31'b0, enable_q};
            bp_pkg::REG_GHR:     rd_data = {{(32-bp_pkg::GHR_BITS){1'b0}}, ghr_i};
            bp_pkg::REG_LOOKUPS: rd_data = lookups_q;
            bp_pkg::REG_HITS:    rd_data = hits_q;
            default:             addr_mapped = 1'b0;
        endcase
    end

    // Bus idles at zero outside a read access
    assign prdata_o  = rd_access ? rd_data : '0;
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && penable_i && !addr_mapped;

    // CTRL bit0 holds enable, bit1 fires a one-cycle flush
    // Flush bit is self clearing so it reads back as 0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            flush_q <= 1'b0;
            if (wr_access && (paddr_i == bp_pkg::REG_CTRL)) begin
                enable_q <= pwdata_i[0];
                flush_q  <= pwdata_i[1];
            end
        end
    end

    // Lookup and hit counters, free running and wrapping
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lookups_q <= '0;
            hits_q    <= '0;
        end else if (lookup_i) begin
            lookups_q <= lookups_q + 32'd1;
            if (hit_i) begin
                hits_q <= hits_q + 32'd1;
            end
        end
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

endmodule

`default_nettype wire

//--- source/bp_gshare.sv
// Gshare direction predictor with global history register and saturating counter table
`timescale 1ns/1ps
`default_nettype none

module bp_gshare (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     flush_i,
    // Fetch side lookup
    input  wire bp_pkg::addr_t      lookup_pc_i,
    // Resolved conditional branch
    input  wire                     upd_en_i,
    input  wire bp_pkg::pht_idx_t   upd_index_i,
    input  wire                     upd_taken_i,
    // Prediction and history readback
    output logic                    predict_taken_o,
    output bp_pkg::pht_idx_t        lookup_index_o,
    output bp_pkg::ghr_t            ghr_o
);

    // Pattern history table and global history
    bp_pkg::ctr_t      pht_q [bp_pkg::PHT_ENTRIES];
    bp_pkg::ghr_t      ghr_q;

    bp_pkg::pht_idx_t  lookup_idx;
    bp_pkg::ctr_t      upd_ctr;
    bp_pkg::ctr_t      upd_ctr_next;

    // PC[6:2] XOR history
    assign lookup_idx = lookup_pc_i[bp_pkg::GHR_BITS+1:2] ^ ghr_q;

    assign lookup_index_o  = lookup_idx;
    assign predict_taken_o = pht_q[lookup_idx][1];
    assign ghr_o           = ghr_q;

    // Counter under update, index was captured at fetch time
    assign upd_ctr = pht_q[upd_index_i];

    // Saturate at 3 going up and at 0 going down
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i) begin
            if (upd_ctr != 2'b11) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else if (upd_ctr != 2'b00) begin
            upd_ctr_next = upd_ctr - 2'd1;
        end
    end

    // Counters survive a flush, only reset brings them back to weakly not-taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                pht_q[i] <= bp_pkg::PHT_RESET;
            end
        end else if (upd_en_i) begin
            pht_q[upd_index_i] <= upd_ctr_next;
        end
    end

    // Newest outcome enters at the MSB, oldest falls off the LSB
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ghr_q <= {upd_taken_i, ghr_q[bp_pkg::GHR_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- source/bp_pkg.sv
// Branch prediction package with widths, table sizes, opcodes, entry kinds and APB register map
`default_nettype none

package bp_pkg;

    // Instruction address
    typedef logic [31:0] addr_t;

    // Direct-mapped BTB, index from PC[6:2] and full tag from PC[31:7]
    localparam int BTB_ENTRIES = 32;
    typedef logic [4:0]  btb_idx_t;
    typedef logic [24:0] btb_tag_t;

    // Gshare history length, also sets the counter table size
    localparam int GHR_BITS    = 5;
    localparam int PHT_ENTRIES = 1 << GHR_BITS;
    typedef logic [GHR_BITS-1:0] ghr_t;
    typedef logic [GHR_BITS-1:0] pht_idx_t;

    // Two-bit saturating counter, MSB is the predicted direction
    typedef logic [1:0] ctr_t;
    // Weakly not-taken
    localparam ctr_t PHT_RESET = 2'b01;

    // RV32I major opcodes that change the control flow
    typedef logic [6:0] opcode_t;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    // Kind stored with each BTB entry
    typedef logic [1:0] br_kind_t;
    localparam br_kind_t KIND_NONE   = 2'd0;
    localparam br_kind_t KIND_BRANCH = 2'd1;
    localparam br_kind_t KIND_JUMP   = 2'd2;

    // APB register offsets
    typedef logic [3:0] apb_addr_t;
    localparam apb_addr_t REG_CTRL    = 4'h0;
    localparam apb_addr_t REG_GHR     = 4'h4;
    localparam apb_addr_t REG_LOOKUPS = 4'h8;
    localparam apb_addr_t REG_HITS    = 4'hC;

endpackage

`default_nettype wire

//--- source/branch_pred_top.sv
// Branch prediction unit top joining the BTB, the gshare predictor and the APB register block
`timescale 1ns/1ps
`default_nettype none

module branch_pred_top (
    input  wire                     clk,
    input  wire                     reset_i,
    // Fetch stage
    input  wire                     fetch_valid_i,
    input  wire bp_pkg::addr_t      fetch_pc_i,
    output logic                    pred_taken_o,
    output bp_pkg::addr_t           pred_target_o,
    output bp_pkg::pht_idx_t        pred_pht_index_o,
    // Execute stage resolution
    input  wire                     update_valid_i,
    input  wire bp_pkg::addr_t      update_pc_i,
    input  wire bp_pkg::opcode_t    update_op_i,
    input  wire                     update_taken_i,
    input  wire bp_pkg::addr_t      update_target_i,
    input  wire bp_pkg::pht_idx_t   update_pht_index_i,
    // APB3 slave
    input  wire                     psel_i,
    input  wire                     penable_i,
    input  wire                     pwrite_i,
    input  wire bp_pkg::apb_addr_t  paddr_i,
    input  wire [31:0]              pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);

    bp_pkg::br_kind_t  upd_kind;
    logic              btb_wr_en;
    logic              pht_upd_en;
    logic              btb_hit;
    bp_pkg::br_kind_t  btb_kind;
    bp_pkg::addr_t     btb_target;
    logic              gshare_taken;
    bp_pkg::ghr_t      ghr;
    logic              enable;
    logic              flush;
    bp_pkg::addr_t     fall_through;

    // Opcode to entry kind, anything else is ignored
    always_comb begin
        case (update_op_i)
            bp_pkg::OP_BRANCH: upd_kind = bp_pkg::KIND_BRANCH;
            bp_pkg::OP_JAL,
            bp_pkg::OP_JALR:   upd_kind = bp_pkg::KIND_JUMP;
            default:           upd_kind = bp_pkg::KIND_NONE;
        endcase
    end

    // Training runs whether or not prediction is enabled
    assign btb_wr_en  = update_valid_i && (upd_kind != bp_pkg::KIND_NONE);
    assign pht_upd_en = update_valid_i && (upd_kind == bp_pkg::KIND_BRANCH);

    bp_btb btb_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush),
        .lookup_pc_i (fetch_pc_i),
        .wr_en_i     (btb_wr_en),
        .wr_pc_i     (update_pc_i),
        .wr_target_i (update_target_i),
        .wr_kind_i   (upd_kind),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target)
    );

    bp_gshare gshare_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush),
        .lookup_pc_i     (fetch_pc_i),
        .upd_en_i        (pht_upd_en),
        .upd_index_i     (update_pht_index_i),
        .upd_taken_i     (update_taken_i),
        .predict_taken_o (gshare_taken),
        .lookup_index_o  (pred_pht_index_o),
        .ghr_o           (ghr)
    );

    bp_csr_apb csr_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .lookup_i  (fetch_valid_i),
        .hit_i     (btb_hit),
        .ghr_i     (ghr),
        .enable_o  (enable),
        .flush_o   (flush)
    );

    assign fall_through = fetch_pc_i + 32'd4;

    // Jumps always redirect, branches follow the counter MSB
    // A not-taken branch hit still reports the stored target
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = fall_through;
        if (enable && btb_hit) begin
            if (btb_kind == bp_pkg::KIND_JUMP) begin
                pred_taken_o  = 1'b1;
                pred_target_o = btb_target;
            end else if (btb_kind == bp_pkg::KIND_BRANCH) begin
                pred_taken_o  = gshare_taken;
                pred_target_o = btb_target;
            end
        end
    end

endmodule

`default_nettype wire
